// File: run.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module dcache_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vdcache_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the testbench prints its verdict into the log
if grep -q "test failed" "$log"; then
	exit 1
fi
if ! grep -q "test passed" "$log"; then
	echo "no verdict found in $log"
	exit 1
fi
exit 0

// File: sources.f
verilog/dcache_pkg.sv
verilog/mem_port_if.sv
verilog/dcache.sv
verilog/tagged_mem.sv
verilog/dcache_sys.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

// File: verif/dcache_asserts.sv
`timescale 1ns/1ps

// memory port protocol and processor side output checks
module dcache_asserts (
	input logic                                clock,
	input logic                                reset,
	input logic                                mem_busy,
	input logic [1:0]                          command,
	input logic [dcache_pkg::MEM_TAG_BITS-1:0] response,
	input logic [dcache_pkg::MEM_TAG_BITS-1:0] rtag,
	input logic                                Dcache_valid_out,
	input logic                                finished
);

	// a tag only comes back for a command the memory could take
	a_response_needs_command: assert property (@(posedge clock) disable iff (reset)
		(response != '0) |-> (command != dcache_pkg::BUS_NONE && !mem_busy))
		else $error("memory response tag without an accepted command");

	// and every command it can take gets one
	a_command_gets_response: assert property (@(posedge clock) disable iff (reset)
		(command != dcache_pkg::BUS_NONE && !mem_busy) |-> (response != '0))
		else $error("command not answered while memory was free");

	a_done_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(Dcache_valid_out && finished))
		else $error("load done and store done in the same cycle");

	// first edge out of reset, nothing pending
	a_quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> (!Dcache_valid_out && !finished && response == '0 && rtag == '0))
		else $error("outputs not idle right after reset");

endmodule

bind dcache_sys dcache_asserts u_dcache_asserts (
	.clock            (clock),
	.reset            (reset),
	.mem_busy         (mem_busy),
	.command          (mem_port.command),
	.response         (mem_port.response),
	.rtag             (mem_port.rtag),
	.Dcache_valid_out (Dcache_valid_out),
	.finished         (finished)
);

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

	localparam int LINES        = 32;
	localparam int LATENCY      = 4;
	localparam int RESET_CYCLES = 10;
	localparam int OP_LIMIT     = 100; // cycles allowed per operation
	localparam int RANDOM_OPS   = 200;

	// how fast an operation should finish
	localparam logic [1:0] VIA_MEM   = 2'd0; // needs the memory, not in the first cycle
	localparam logic [1:0] AT_ONCE   = 2'd1; // done in the cycle it is applied
	localparam logic [1:0] ANY_SPEED = 2'd2;

	typedef struct packed {
		logic [1:0]  cmd;
		logic [31:0] addr;
		logic [63:0] data;
		int          busy;  // cycles of mem_busy at the start of the op
		logic [1:0]  speed;
	} op_t;

	logic        clock;
	logic        reset;
	logic        mem_busy;
	logic [31:0] proc2Dcache_addr;
	logic [63:0] proc2Dcache_data;
	logic [1:0]  proc2Dcache_command;
	logic [63:0] Dcache_data_out;
	logic        Dcache_valid_out;
	logic        finished;

	op_t         ops[$];
	logic        ops_ready;
	int          errors;
	logic [63:0] shadow [logic [12:0]]; // doublewords written so far

	dcache_sys #(
		.DCACHE_LINES (LINES),
		.MEM_LATENCY  (LATENCY)
	) u_dcache_sys (
		.clock               (clock),
		.reset               (reset),
		.mem_busy            (mem_busy),
		.proc2Dcache_addr    (proc2Dcache_addr),
		.proc2Dcache_data    (proc2Dcache_data),
		.proc2Dcache_command (proc2Dcache_command),
		.Dcache_data_out     (Dcache_data_out),
		.Dcache_valid_out    (Dcache_valid_out),
		.finished            (finished)
	);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [12:0] dword_of(input logic [31:0] addr);
		return addr[15:3]; // memory ignores bits 2..0 and everything above 15
	endfunction

	// shadow value, or the start pattern if never written
	function automatic logic [63:0] shadow_read(input logic [12:0] key);
		logic [31:0] upper;
		if (shadow.exists(key)) begin
			return shadow[key];
		end
		upper = 32'hD000_0000 + {19'd0, key};
		return {upper, ~upper};
	endfunction

	function automatic void add_op(input logic [1:0] cmd, input logic [31:0] addr,
			input logic [63:0] data, input int busy, input logic [1:0] speed);
		op_t op;
		op.cmd   = cmd;
		op.addr  = addr;
		op.data  = data;
		op.busy  = busy;
		op.speed = speed;
		ops.push_back(op);
	endfunction

	// directed table, 32 lines so index is bits 7..3 and tag bits 15..8
	function automatic void build_table();
		add_op(dcache_pkg::BUS_LOAD,  32'h0040, 64'h0, 0, VIA_MEM);  // cold miss, start pattern
		add_op(dcache_pkg::BUS_LOAD,  32'h0040, 64'h0, 0, AT_ONCE);  // same line, hit
		add_op(dcache_pkg::BUS_STORE, 32'h0040, 64'h1111_2222_3333_4444, 0, AT_ONCE);
		add_op(dcache_pkg::BUS_LOAD,  32'h0040, 64'h0, 0, AT_ONCE);
		add_op(dcache_pkg::BUS_STORE, 32'h0048, 64'hB0B0_0000_0000_B0B0, 0, AT_ONCE);
		add_op(dcache_pkg::BUS_LOAD,  32'h0148, 64'h0, 0, VIA_MEM);  // evicts dirty 0x48
		add_op(dcache_pkg::BUS_LOAD,  32'h0048, 64'h0, 0, VIA_MEM);  // written back value
		add_op(dcache_pkg::BUS_STORE, 32'h0248, 64'hC0C0_1234_5678_C0C0, 0, AT_ONCE);
		add_op(dcache_pkg::BUS_STORE, 32'h0348, 64'hD0D0_8765_4321_D0D0, 0, VIA_MEM);
		add_op(dcache_pkg::BUS_LOAD,  32'h0248, 64'h0, 6, VIA_MEM);  // busy over write-back
		add_op(dcache_pkg::BUS_LOAD,  32'h0348, 64'h0, 3, VIA_MEM);
		add_op(dcache_pkg::BUS_LOAD,  32'h1000, 64'h0, 5, VIA_MEM);
		add_op(dcache_pkg::BUS_STORE, 32'h1006, 64'hEEEE_0101_0202_EEEE, 0, AT_ONCE);
		add_op(dcache_pkg::BUS_LOAD,  32'h1003, 64'h0, 0, AT_ONCE);  // offset bits ignored
		add_op(dcache_pkg::BUS_LOAD,  32'h0040, 64'h0, 0, AT_ONCE);
	endfunction

	// eight addresses: tags 0x20/0x21 on indices 16..19
	function automatic void add_random_ops();
		logic [31:0] state;
		logic [31:0] ctrl;
		logic [31:0] hi;
		int          busy;
		state = 32'h366c0986;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			state = xorshift(state);
			ctrl  = state;
			state = xorshift(state);
			hi    = state;
			state = xorshift(state);
			busy  = 0;
			if (ctrl[7:4] == 4'hf) begin
				busy = 32'(ctrl[9:8]) + 1; // now and then the icache takes the memory
			end
			add_op(ctrl[3] ? dcache_pkg::BUS_STORE : dcache_pkg::BUS_LOAD,
				{16'd0, 7'b0010000, ctrl[2], 3'b100, ctrl[1:0], 3'b000},
				{hi, state}, busy, ANY_SPEED);
		end
	endfunction

	// called 1 ns after a rising edge, returns at the same point of a later cycle
	task automatic run_op(input int n, input op_t op);
		int          cycles;
		logic        done;
		logic [12:0] key;
		logic [63:0] expected;
		key      = dword_of(op.addr);
		expected = shadow_read(key);
		proc2Dcache_command = op.cmd;
		proc2Dcache_addr    = op.addr;
		proc2Dcache_data    = op.data;
		mem_busy            = (op.busy > 0);
		cycles = 0;
		done   = 1'b0;
		while (!done && cycles < OP_LIMIT) begin
			@(negedge clock); // outputs settled, inputs held
			if (op.cmd == dcache_pkg::BUS_LOAD && Dcache_valid_out) begin
				done = 1'b1;
				if (Dcache_data_out !== expected) begin
					$display("FAILED t=%0t Dcache_data_out got %h expected %h (op %0d addr %h)",
						$time, Dcache_data_out, expected, n, op.addr);
					errors++;
				end
			end else if (op.cmd == dcache_pkg::BUS_STORE && finished) begin
				done = 1'b1;
				shadow[key] = op.data;
			end
			if (done && op.speed == AT_ONCE && cycles != 0) begin
				$display("op %0d to %h took %0d cycles but should have finished at once",
					n, op.addr, cycles + 1);
				errors++;
			end
			if (done && op.speed == VIA_MEM && cycles == 0) begin
				$display("op %0d to %h finished at once but should have gone to memory",
					n, op.addr);
				errors++;
			end
			@(posedge clock);
			#1;
			cycles++;
			mem_busy = (cycles < op.busy);
		end
		if (!done) begin
			$display("op %0d (command %0d at %h) never completed within %0d cycles",
				n, op.cmd, op.addr, OP_LIMIT);
			errors++;
		end
	endtask

	initial begin
		errors              = 0;
		ops_ready           = 1'b0;
		reset               = 1'b1;
		mem_busy            = 1'b0;
		proc2Dcache_command = dcache_pkg::BUS_NONE;
		proc2Dcache_addr    = '0;
		proc2Dcache_data    = '0;
		build_table();
		add_random_ops();
		ops_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (2) @(posedge clock); // idle a little before the first request
		#1;
		for (int n = 0; n < ops.size(); n++) begin
			run_op(n, ops[n]);
		end
		proc2Dcache_command = dcache_pkg::BUS_NONE;
		mem_busy            = 1'b0;
		$display("%0d errors in %0d operations", errors, ops.size());
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// run length bound: every op at its limit plus reset
	initial begin
		int limit;
		wait (ops_ready);
		limit = ops.size() * OP_LIMIT + RESET_CYCLES + 4;
		repeat (limit) @(posedge clock);
		$display("watchdog: run still going after %0d cycles", limit);
		$display("test failed");
		$finish;
	end

endmodule

// File: verilog/dcache.sv
`timescale 1ns/1ps

// direct-mapped, write-back, write-allocate data cache
// one doubleword per line
module dcache #(
	parameter int DCACHE_LINES = 32 // power of two, up to 4096
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [dcache_pkg::XLEN-1:0]         proc2Dcache_addr,
	input  logic [dcache_pkg::DWORD_BITS-1:0]   proc2Dcache_data,
	input  logic [1:0]                          proc2Dcache_command, // held until done
	output logic [dcache_pkg::DWORD_BITS-1:0]   Dcache_data_out,
	output logic                                Dcache_valid_out,    // load done
	output logic                                finished,            // store done
	mem_port_if.cache                           mem
);

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int TAG_BITS   = dcache_pkg::DWORD_ADDR_BITS - INDEX_BITS;
	localparam int PAD_BITS   = dcache_pkg::XLEN - dcache_pkg::MEM_ADDR_BITS;

	// line storage
	logic [dcache_pkg::DWORD_BITS-1:0] line_data [DCACHE_LINES];
	logic [TAG_BITS-1:0]               line_tag  [DCACHE_LINES];
	logic [DCACHE_LINES-1:0]           line_valid;
	logic [DCACHE_LINES-1:0]           line_dirty;

	// cache tag and index, not memory tags
	logic [TAG_BITS-1:0]   cur_tag, last_tag;
	logic [INDEX_BITS-1:0] cur_index, last_index;

	logic is_load, is_store;
	logic hit;
	logic victim_dirty;  // line holds another address and must go back first
	logic store_nwrite;  // store that can be written into the line right away
	logic need_mem;      // current request cannot finish without the memory

	// outstanding load tracking
	logic [dcache_pkg::MEM_TAG_BITS-1:0] mem_tag; // response tag we wait on
	logic miss_outstanding;  // a load was accepted and its data is not back yet
	logic changed_addr;
	logic load_pending;
	logic issue;             // drive a command on the memory port this cycle
	logic mem_accepted;
	logic load_accepted;
	logic wb_accepted;       // victim write-back taken by the memory
	logic got_mem_data;

	assign {cur_tag, cur_index} =
		proc2Dcache_addr[dcache_pkg::MEM_ADDR_BITS-1:dcache_pkg::OFFSET_BITS];

	assign is_load  = (proc2Dcache_command == dcache_pkg::BUS_LOAD);
	assign is_store = (proc2Dcache_command == dcache_pkg::BUS_STORE);

	// hit detect
	assign hit = line_valid[cur_index] && (line_tag[cur_index] == cur_tag);
	assign victim_dirty = line_valid[cur_index] && line_dirty[cur_index] && !hit;

	// processor side outputs, all combinational on the held request
	assign Dcache_data_out  = line_data[cur_index];
	assign Dcache_valid_out = hit && is_load;
	assign store_nwrite     = is_store && !victim_dirty; // hit, clean or invalid line
	assign finished         = store_nwrite;

	// load miss, or store that first has to push out a dirty victim
	assign need_mem = (is_load && !hit) || (is_store && victim_dirty);

	// a new address abandons whatever load was in flight
	assign changed_addr = (cur_tag != last_tag) || (cur_index != last_index);
	assign load_pending = miss_outstanding && !changed_addr;

	// keep re-presenting the request until the memory answers
	assign issue = need_mem && !load_pending;

	assign mem_accepted  = (mem.response != '0); // only nonzero for our own command
	assign load_accepted = mem_accepted && issue && !victim_dirty;
	assign wb_accepted   = mem_accepted && issue && victim_dirty;

	// returned tag matches the one saved at acceptance
	assign got_mem_data = load_pending && (mem.rtag == mem_tag);

	// write-back of the victim takes precedence over the current address
	always_comb begin
		mem.command = dcache_pkg::BUS_NONE;
		if (issue) begin
			mem.command = victim_dirty ? dcache_pkg::BUS_STORE : dcache_pkg::BUS_LOAD;
		end
	end

	always_comb begin
		if (victim_dirty) begin
			// rebuild the victim's address from its tag and our index
			mem.addr = {{PAD_BITS{1'b0}}, line_tag[cur_index], cur_index,
				{dcache_pkg::OFFSET_BITS{1'b0}}};
		end else begin
			mem.addr = {proc2Dcache_addr[dcache_pkg::XLEN-1:dcache_pkg::OFFSET_BITS],
				{dcache_pkg::OFFSET_BITS{1'b0}}};
		end
	end

	assign mem.wdata = line_data[cur_index]; // only looked at for write-backs

	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid       <= '0;    // every line invalid and clean
			line_dirty       <= '0;
			last_tag         <= '1;
			last_index       <= '1;
			miss_outstanding <= 1'b0;
			mem_tag          <= '0;
		end else begin
			last_tag   <= cur_tag;
			last_index <= cur_index;

			if (load_accepted) begin
				miss_outstanding <= 1'b1;
				mem_tag          <= mem.response;
			end else if (got_mem_data || changed_addr) begin
				miss_outstanding <= 1'b0; // filled, or the processor moved on
			end

			// refill comes in clean
			if (got_mem_data) begin
				line_valid[cur_index] <= 1'b1;
				line_dirty[cur_index] <= 1'b0;
			end

			if (store_nwrite) begin
				line_valid[cur_index] <= 1'b1;
				line_dirty[cur_index] <= 1'b1;
			end

			// victim now safe in memory
			if (wb_accepted) begin
				line_dirty[cur_index] <= 1'b0;
			end
		end
	end

	// payload, data and tag arrays
	always_ff @(posedge clock) begin
		if (got_mem_data) begin
			line_data[cur_index] <= mem.rdata;
			line_tag[cur_index]  <= cur_tag;
		end else if (store_nwrite) begin
			line_data[cur_index] <= proc2Dcache_data;
			line_tag[cur_index]  <= cur_tag;
		end else if (wb_accepted && is_store) begin
			// store miss: retag now, the store lands next cycle as a hit
			line_tag[cur_index] <= cur_tag;
		end
	end

endmodule

// File: verilog/dcache_pkg.sv
package dcache_pkg;

	// processor address width
	localparam int XLEN = 32;

	// command codes, same on processor side and memory side
	localparam logic [1:0] BUS_NONE  = 2'd0;
	localparam logic [1:0] BUS_LOAD  = 2'd1;
	localparam logic [1:0] BUS_STORE = 2'd2;

	// memory only decodes address bits 15..0
	localparam int MEM_ADDR_BITS = 16;
	localparam int OFFSET_BITS   = 3;  // byte offset inside a doubleword, ignored

	// bits 15..3 name one doubleword
	localparam int DWORD_ADDR_BITS = MEM_ADDR_BITS - OFFSET_BITS;
	localparam int MEM_DWORDS      = 2 ** DWORD_ADDR_BITS; // 8192 doublewords

	// transaction tag, 0 means no response
	localparam int MEM_TAG_BITS = 4;

	// every data path is one doubleword wide
	localparam int DWORD_BITS = 64;

	// upper half of memory word i starts as this base plus i,
	// lower half is its inverse
	localparam logic [31:0] MEM_PATTERN_BASE = 32'hD000_0000;

endpackage

// File: verilog/dcache_sys.sv
`timescale 1ns/1ps

// data cache in front of the tagged memory
module dcache_sys #(
	parameter int DCACHE_LINES = 32,
	parameter int MEM_LATENCY  = 4
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                mem_busy,  // icache has the memory
	input  logic [dcache_pkg::XLEN-1:0]         proc2Dcache_addr,
	input  logic [dcache_pkg::DWORD_BITS-1:0]   proc2Dcache_data,
	input  logic [1:0]                          proc2Dcache_command,
	output logic [dcache_pkg::DWORD_BITS-1:0]   Dcache_data_out,
	output logic                                Dcache_valid_out,
	output logic                                finished
);

	mem_port_if mem_port ();

	dcache #(
		.DCACHE_LINES (DCACHE_LINES)
	) u_dcache (
		.clock               (clock),
		.reset               (reset),
		.proc2Dcache_addr    (proc2Dcache_addr),
		.proc2Dcache_data    (proc2Dcache_data),
		.proc2Dcache_command (proc2Dcache_command),
		.Dcache_data_out     (Dcache_data_out),
		.Dcache_valid_out    (Dcache_valid_out),
		.finished            (finished),
		.mem                 (mem_port.cache)
	);

	tagged_mem #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clock    (clock),
		.reset    (reset),
		.mem_busy (mem_busy),
		.mem      (mem_port.memory)
	);

endmodule

// File: verilog/mem_port_if.sv
`timescale 1ns/1ps

// cache to memory port, one outstanding command per cycle
interface mem_port_if;

	logic [1:0]                           command;  // BUS_NONE, BUS_LOAD or BUS_STORE
	logic [dcache_pkg::XLEN-1:0]          addr;
	logic [dcache_pkg::DWORD_BITS-1:0]    wdata;    // store data, write-backs only
	logic [dcache_pkg::MEM_TAG_BITS-1:0]  response; // nonzero when command accepted
	logic [dcache_pkg::DWORD_BITS-1:0]    rdata;
	logic [dcache_pkg::MEM_TAG_BITS-1:0]  rtag;     // tag of the load returning now

	modport cache (
		output command, addr, wdata,
		input  response, rdata, rtag
	);

	modport memory (
		input  command, addr, wdata,
		output response, rdata, rtag
	);

endinterface

// File: verilog/tagged_mem.sv
`timescale 1ns/1ps

// doubleword memory with transaction tags
// loads come back MEM_LATENCY cycles after acceptance, stores land at once
module tagged_mem #(
	parameter int MEM_LATENCY = 4 // at least 1
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        mem_busy, // instruction side owns the memory this cycle
	mem_port_if.memory  mem
);

	localparam logic [dcache_pkg::MEM_TAG_BITS-1:0] FIRST_TAG = 1;

	logic [dcache_pkg::DWORD_BITS-1:0]      mem_data [dcache_pkg::MEM_DWORDS];
	logic [dcache_pkg::DWORD_ADDR_BITS-1:0] dword_addr;
	logic [dcache_pkg::MEM_TAG_BITS-1:0]    next_tag;   // tag for the next accepted command
	logic                                   accepted;
	logic                                   load_accepted;
	logic                                   store_accepted;

	// load return pipeline, stage MEM_LATENCY-1 drives the port
	logic [dcache_pkg::MEM_TAG_BITS-1:0] pipe_tag  [MEM_LATENCY];
	logic [dcache_pkg::DWORD_BITS-1:0]   pipe_data [MEM_LATENCY];

	// fixed start pattern
	initial begin
		logic [31:0] upper;
		for (int i = 0; i < dcache_pkg::MEM_DWORDS; i++) begin
			upper = dcache_pkg::MEM_PATTERN_BASE + 32'(i);
			mem_data[i] = {upper, ~upper};
		end
	end

	assign dword_addr =
		mem.addr[dcache_pkg::MEM_ADDR_BITS-1:dcache_pkg::OFFSET_BITS]; // low 3 bits dropped

	assign accepted       = (mem.command != dcache_pkg::BUS_NONE) && !mem_busy;
	assign load_accepted  = accepted && (mem.command == dcache_pkg::BUS_LOAD);
	assign store_accepted = accepted && (mem.command == dcache_pkg::BUS_STORE);

	// answer in the same cycle, 0 while busy or idle
	assign mem.response = accepted ? next_tag : '0;

	assign mem.rtag  = pipe_tag[MEM_LATENCY-1];
	assign mem.rdata = pipe_data[MEM_LATENCY-1];

	// store is complete once accepted
	always @(posedge clock) begin
		if (store_accepted) begin
			mem_data[dword_addr] <= mem.wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= FIRST_TAG;
			for (int s = 0; s < MEM_LATENCY; s++) begin
				pipe_tag[s] <= '0;
			end
		end else begin
			if (accepted) begin
				// 1..15, skip 0
				next_tag <= (next_tag == '1) ? FIRST_TAG : next_tag + FIRST_TAG;
			end
			pipe_tag[0] <= load_accepted ? next_tag : '0; // bubble when no load
			for (int s = 1; s < MEM_LATENCY; s++) begin
				pipe_tag[s] <= pipe_tag[s-1];
			end
		end
	end

	// data rides alongside its tag
	always_ff @(posedge clock) begin
		pipe_data[0] <= mem_data[dword_addr];
		for (int s = 1; s < MEM_LATENCY; s++) begin
			pipe_data[s] <= pipe_data[s-1];
		end
	end

endmodule
